/* common/vrf_cfg.svh */
//////////////////////////////////////////////////
// Sizing of the banked vector register file.
// The crossbars are hand-mapped for exactly 3 write
// and 5 read ports, so changing those counts alone breaks them.
//////////////////////////////////////////////////
`ifndef VRF_CFG_SVH
`define VRF_CFG_SVH

// Register file geometry
`define VRF_NR_VREG 32
`define VRF_VLEN 256
`define VRF_ELEN 32

// Banking, every bank holds two elements per register
`define VRF_NR_BANKS 4

// Requester ports seen at the top level
`define VRF_NR_WPORTS 3
`define VRF_NR_RPORTS 5

// Read ports inside one bank
`define VRF_BANK_RPORTS 3

`endif

/* common/vrf_pkg.sv */
//////////////////////////////////////////////////
// Types shared by the vector register file.
// Address layout is {vreg, bank, elem} from the MSB.
//////////////////////////////////////////////////
package vrf_pkg;

  `include "vrf_cfg.svh"

  // Derived field widths
  localparam int unsigned elem_per_bank = `VRF_VLEN / (`VRF_ELEN * `VRF_NR_BANKS);
  localparam int unsigned vreg_idx_w    = $clog2(`VRF_NR_VREG);
  localparam int unsigned bank_idx_w    = $clog2(`VRF_NR_BANKS);
  localparam int unsigned elem_idx_w    = $clog2(elem_per_bank);

  typedef logic [`VRF_ELEN-1:0]   vreg_data_t;
  typedef logic [`VRF_ELEN/8-1:0] vreg_be_t;
  typedef logic [bank_idx_w-1:0]  bank_sel_t;

  // Address inside one bank, register index then element
  typedef logic [vreg_idx_w+elem_idx_w-1:0] bank_addr_t;

  typedef struct packed {
    logic [vreg_idx_w-1:0] vreg;
    bank_sel_t             bank;
    logic [elem_idx_w-1:0] elem;
  } vreg_addr_fields_t;

  // Same address word, flat or split into fields
  typedef union packed {
    logic [vreg_idx_w+bank_idx_w+elem_idx_w-1:0] raw;
    vreg_addr_fields_t                           fields;
  } vreg_addr_u;

  // Write requesters, lower index wins
  localparam int unsigned WP_VD  = 0;
  localparam int unsigned WP_LSU = 1;
  localparam int unsigned WP_SLD = 2;

  // Read requesters
  localparam int unsigned RP_VS2 = 0;
  localparam int unsigned RP_VS1 = 1;
  localparam int unsigned RP_VD  = 2;
  localparam int unsigned RP_LSU = 3;
  localparam int unsigned RP_SLD = 4;

  // Drop the bank field to get the in-bank address
  function automatic bank_addr_t to_bank_addr(vreg_addr_u addr);
    return {addr.fields.vreg, addr.fields.elem};
  endfunction

endpackage

/* common/vrf_bank_if.sv */
//////////////////////////////////////////////////
// Signals of one register bank.
// One write port and three read ports per bank.
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "vrf_cfg.svh"

interface vrf_bank_if;

  import vrf_pkg::*;

  // Write side
  logic       we;
  bank_addr_t waddr;
  vreg_data_t wdata;
  vreg_be_t   wbe;

  // Read side, one entry per bank read port
  bank_addr_t [`VRF_BANK_RPORTS-1:0] raddr;
  vreg_data_t [`VRF_BANK_RPORTS-1:0] rdata;

  modport wr_xbar (
    output we,
    output waddr,
    output wdata,
    output wbe
  );

  modport rd_xbar (
    output raddr,
    input  rdata
  );

  modport bank (
    input  we,
    input  waddr,
    input  wdata,
    input  wbe,
    input  raddr,
    output rdata
  );

endinterface

/* vrf/vrf_write_xbar.sv */
//////////////////////////////////////////////////
// Fixed-priority write routing, vd over lsu over sld.
// Ready is a same-cycle grant. A refused port must hold
// its request because nothing is queued here.
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "vrf_cfg.svh"

module vrf_write_xbar (
  input  logic                [`VRF_NR_WPORTS-1:0] wvalid_i,
  input  vrf_pkg::vreg_addr_u [`VRF_NR_WPORTS-1:0] waddr_i,
  input  vrf_pkg::vreg_data_t [`VRF_NR_WPORTS-1:0] wdata_i,
  input  vrf_pkg::vreg_be_t   [`VRF_NR_WPORTS-1:0] wbe_i,
  output logic                [`VRF_NR_WPORTS-1:0] wready_o,
  vrf_bank_if.wr_xbar         bank_o [`VRF_NR_BANKS]
);

  import vrf_pkg::*;

  logic [`VRF_NR_WPORTS-1:0][`VRF_NR_BANKS-1:0] hit;

  logic       [`VRF_NR_BANKS-1:0] bank_we;
  bank_addr_t [`VRF_NR_BANKS-1:0] bank_waddr;
  vreg_data_t [`VRF_NR_BANKS-1:0] bank_wdata;
  vreg_be_t   [`VRF_NR_BANKS-1:0] bank_wbe;

  // Which bank each valid port targets
  always_comb begin : proc_hit
    for (int unsigned p = 0; p < `VRF_NR_WPORTS; p++) begin
      for (int unsigned b = 0; b < `VRF_NR_BANKS; b++) begin
        hit[p][b] = wvalid_i[p] && (waddr_i[p].fields.bank == bank_sel_t'(b));
      end
    end
  end

  //////////////////////////////////////////////////
  // Bank write port arbitration
  //////////////////////////////////////////////////

  always_comb begin : proc_write_map
    int unsigned sel;
    sel        = WP_VD;
    bank_we    = '0;
    bank_waddr = '0;
    bank_wdata = '0;
    bank_wbe   = '0;
    wready_o   = '0;
    for (int unsigned b = 0; b < `VRF_NR_BANKS; b++) begin
      bank_we[b] = 1'b1;
      if (hit[WP_VD][b]) begin
        sel = WP_VD;
      end else if (hit[WP_LSU][b]) begin
        sel = WP_LSU;
      end else if (hit[WP_SLD][b]) begin
        sel = WP_SLD;
      end else begin
        bank_we[b] = 1'b0;
      end
      if (bank_we[b]) begin
        bank_waddr[b] = to_bank_addr(waddr_i[sel]);
        bank_wdata[b] = wdata_i[sel];
        bank_wbe[b]   = wbe_i[sel];
        wready_o[sel] = 1'b1;
      end
    end
  end

  for (genvar b = 0; b < `VRF_NR_BANKS; b++) begin : gen_bank_drive
    assign bank_o[b].we    = bank_we[b];
    assign bank_o[b].waddr = bank_waddr[b];
    assign bank_o[b].wdata = bank_wdata[b];
    assign bank_o[b].wbe   = bank_wbe[b];
  end

endmodule

/* vrf/vrf_read_xbar.sv */
//////////////////////////////////////////////////
// Read routing onto three read ports per bank.
// Port 0 vs2, port 1 vs1 then sld, port 2 vd, lsu, sld.
// Data is combinational and zero while not granted.
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "vrf_cfg.svh"

module vrf_read_xbar (
  input  logic                [`VRF_NR_RPORTS-1:0] rvalid_i,
  input  vrf_pkg::vreg_addr_u [`VRF_NR_RPORTS-1:0] raddr_i,
  output logic                [`VRF_NR_RPORTS-1:0] rready_o,
  output vrf_pkg::vreg_data_t [`VRF_NR_RPORTS-1:0] rdata_o,
  vrf_bank_if.rd_xbar         bank_o [`VRF_NR_BANKS]
);

  import vrf_pkg::*;

  logic [`VRF_NR_RPORTS-1:0][`VRF_NR_BANKS-1:0] hit;

  bank_addr_t [`VRF_NR_BANKS-1:0][`VRF_BANK_RPORTS-1:0] bank_raddr;
  vreg_data_t [`VRF_NR_BANKS-1:0][`VRF_BANK_RPORTS-1:0] bank_rdata;

  always_comb begin : proc_hit
    for (int unsigned p = 0; p < `VRF_NR_RPORTS; p++) begin
      for (int unsigned b = 0; b < `VRF_NR_BANKS; b++) begin
        hit[p][b] = rvalid_i[p] && (raddr_i[p].fields.bank == bank_sel_t'(b));
      end
    end
  end

  //////////////////////////////////////////////////
  // Per-bank priority groups
  //////////////////////////////////////////////////

  always_comb begin : proc_read_map
    logic        [`VRF_BANK_RPORTS-1:0] busy;
    int unsigned                        sel [`VRF_BANK_RPORTS];
    busy       = '0;
    sel        = '{default: RP_VS2};
    bank_raddr = '0;
    rready_o   = '0;
    rdata_o    = '0;
    for (int unsigned b = 0; b < `VRF_NR_BANKS; b++) begin
      busy = '0;
      // Port 0 is private to vs2
      if (hit[RP_VS2][b]) begin
        busy[0] = 1'b1;
        sel[0]  = RP_VS2;
      end
      // Port 1
      if (hit[RP_VS1][b]) begin
        busy[1] = 1'b1;
        sel[1]  = RP_VS1;
      end else if (hit[RP_SLD][b]) begin
        busy[1] = 1'b1;
        sel[1]  = RP_SLD;
      end
      // Port 2, sld only if port 1 did not already take it
      if (hit[RP_VD][b]) begin
        busy[2] = 1'b1;
        sel[2]  = RP_VD;
      end else if (hit[RP_LSU][b]) begin
        busy[2] = 1'b1;
        sel[2]  = RP_LSU;
      end else if (hit[RP_SLD][b] && !(busy[1] && sel[1] == RP_SLD)) begin
        busy[2] = 1'b1;
        sel[2]  = RP_SLD;
      end
      // Steer address out and data back
      for (int unsigned k = 0; k < `VRF_BANK_RPORTS; k++) begin
        if (busy[k]) begin
          bank_raddr[b][k]  = to_bank_addr(raddr_i[sel[k]]);
          rready_o[sel[k]]  = 1'b1;
          rdata_o[sel[k]]   = bank_rdata[b][k];
        end
      end
    end
  end

  for (genvar b = 0; b < `VRF_NR_BANKS; b++) begin : gen_bank_conn
    assign bank_o[b].raddr = bank_raddr[b];
    assign bank_rdata[b]   = bank_o[b].rdata;
  end

endmodule

/* vrf/vrf_bank.sv */
//////////////////////////////////////////////////
// One register bank in flip-flops, cleared on reset.
// Reads are combinational and see the value from
// before a write in the same cycle.
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "vrf_cfg.svh"

module vrf_bank (
  input  logic        clk,
  input  logic        rst_ni,
  vrf_bank_if.bank    port_i
);

  import vrf_pkg::*;

  // 32 registers times two elements per bank
  localparam int unsigned depth = `VRF_NR_VREG * elem_per_bank;
  localparam int unsigned nr_bytes = $bits(vreg_be_t);

  vreg_data_t [depth-1:0] mem_q;

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_ni) begin
      mem_q <= '0;
    end else if (port_i.we) begin
      // Only enabled bytes change
      for (int unsigned k = 0; k < nr_bytes; k++) begin
        if (port_i.wbe[k]) begin
          mem_q[port_i.waddr][8*k +: 8] <= port_i.wdata[8*k +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////

  for (genvar r = 0; r < `VRF_BANK_RPORTS; r++) begin : gen_read
    assign port_i.rdata[r] = mem_q[port_i.raddr[r]];
  end

endmodule

/* hdl/vrf_top.sv */
//////////////////////////////////////////////////
// Banked vector register file, 32 x 256 bit in 4 banks.
// Ready is the same-cycle grant for each port. Write ports
// vd, lsu, sld and read ports vs2, vs1, vd, lsu, sld.
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "vrf_cfg.svh"

module vrf_top (
  input  logic clk,
  input  logic rst_ni,
  // Write ports
  input  logic [`VRF_NR_WPORTS-1:0]                                    wvalid_i,
  input  logic [`VRF_NR_WPORTS-1:0][$bits(vrf_pkg::vreg_addr_u)-1:0] waddr_i,
  input  logic [`VRF_NR_WPORTS-1:0][`VRF_ELEN-1:0]                   wdata_i,
  input  logic [`VRF_NR_WPORTS-1:0][`VRF_ELEN/8-1:0]                 wbe_i,
  output logic [`VRF_NR_WPORTS-1:0]                                    wready_o,
  // Read ports
  input  logic [`VRF_NR_RPORTS-1:0]                                    rvalid_i,
  input  logic [`VRF_NR_RPORTS-1:0][$bits(vrf_pkg::vreg_addr_u)-1:0] raddr_i,
  output logic [`VRF_NR_RPORTS-1:0]                                    rready_o,
  output logic [`VRF_NR_RPORTS-1:0][`VRF_ELEN-1:0]                   rdata_o
);

  import vrf_pkg::*;

  vreg_addr_u [`VRF_NR_WPORTS-1:0] waddr;
  vreg_data_t [`VRF_NR_WPORTS-1:0] wdata;
  vreg_be_t   [`VRF_NR_WPORTS-1:0] wbe;
  vreg_addr_u [`VRF_NR_RPORTS-1:0] raddr;
  vreg_data_t [`VRF_NR_RPORTS-1:0] rdata;

  //////////////////////////////////////////////////
  // Flat ports to typed words
  //////////////////////////////////////////////////

  for (genvar p = 0; p < `VRF_NR_WPORTS; p++) begin : gen_wsplit
    assign waddr[p].raw = waddr_i[p];
    assign wdata[p]     = wdata_i[p];
    assign wbe[p]       = wbe_i[p];
  end

  for (genvar p = 0; p < `VRF_NR_RPORTS; p++) begin : gen_rsplit
    assign raddr[p].raw = raddr_i[p];
    assign rdata_o[p]   = rdata[p];
  end

  //////////////////////////////////////////////////
  // Crossbars and banks
  //////////////////////////////////////////////////

  vrf_bank_if bank_if [`VRF_NR_BANKS] ();

  vrf_write_xbar i_write_xbar (
    .wvalid_i ( wvalid_i ),
    .waddr_i  ( waddr    ),
    .wdata_i  ( wdata    ),
    .wbe_i    ( wbe      ),
    .wready_o ( wready_o ),
    .bank_o   ( bank_if  )
  );

  vrf_read_xbar i_read_xbar (
    .rvalid_i ( rvalid_i ),
    .raddr_i  ( raddr    ),
    .rready_o ( rready_o ),
    .rdata_o  ( rdata    ),
    .bank_o   ( bank_if  )
  );

  for (genvar b = 0; b < `VRF_NR_BANKS; b++) begin : gen_banks
    vrf_bank i_bank (
      .clk    ( clk        ),
      .rst_ni ( rst_ni     ),
      .port_i ( bank_if[b] )
    );
  end

endmodule

/* tb/tb_clk_gen.sv */
//////////////////////////////////////////////////
// Clock of 4 ns period and an active-low reset that
// is held for the first 3 rising edges.
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

/* tb/vrf_properties.sv */
//////////////////////////////////////////////////
// Checks for vrf_top, attached by bind.
// Shadow copy follows every accepted write; the expected
// grants come from the fixed port priorities.
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "vrf_cfg.svh"

module vrf_properties (
  input logic clk,
  input logic rst_ni,
  input logic [`VRF_NR_WPORTS-1:0]                                  wvalid_i,
  input logic [`VRF_NR_WPORTS-1:0][$bits(vrf_pkg::vreg_addr_u)-1:0] waddr_i,
  input logic [`VRF_NR_WPORTS-1:0][`VRF_ELEN-1:0]                   wdata_i,
  input logic [`VRF_NR_WPORTS-1:0][`VRF_ELEN/8-1:0]                 wbe_i,
  input logic [`VRF_NR_WPORTS-1:0]                                  wready_i,
  input logic [`VRF_NR_RPORTS-1:0]                                  rvalid_i,
  input logic [`VRF_NR_RPORTS-1:0][$bits(vrf_pkg::vreg_addr_u)-1:0] raddr_i,
  input logic [`VRF_NR_RPORTS-1:0]                                  rready_i,
  input logic [`VRF_NR_RPORTS-1:0][`VRF_ELEN-1:0]                   rdata_i
);

  import vrf_pkg::*;

  localparam int unsigned nr_addr = 2 ** $bits(vreg_addr_u);

  int unsigned err_count = 0;

  vreg_data_t                      shadow_q [nr_addr];
  logic       [`VRF_NR_WPORTS-1:0] exp_wready;
  logic       [`VRF_NR_RPORTS-1:0] exp_rready;
  vreg_data_t [`VRF_NR_RPORTS-1:0] exp_rdata;

  // Another port's valid request on the same bank
  function automatic logic claims_bank(logic valid, vreg_addr_u other, vreg_addr_u mine);
    return valid && (other.fields.bank == mine.fields.bank);
  endfunction

  // Shadow merge of enabled bytes
  always_ff @(posedge clk) begin
    if (!rst_ni) begin
      shadow_q <= '{default: '0};
    end else begin
      for (int unsigned p = 0; p < `VRF_NR_WPORTS; p++) begin
        if (wvalid_i[p] && wready_i[p]) begin
          for (int unsigned k = 0; k < `VRF_ELEN / 8; k++) begin
            if (wbe_i[p][k]) begin
              shadow_q[waddr_i[p]][8*k +: 8] <= wdata_i[p][8*k +: 8];
            end
          end
        end
      end
    end
  end

  always_comb begin : proc_expect
    logic slot1_taken;
    logic slot2_taken;
    // Lower write index wins the bank
    for (int unsigned p = 0; p < `VRF_NR_WPORTS; p++) begin
      exp_wready[p] = wvalid_i[p];
      for (int unsigned q = 0; q < p; q++) begin
        if (claims_bank(wvalid_i[q], waddr_i[q], waddr_i[p])) begin
          exp_wready[p] = 1'b0;
        end
      end
    end
    exp_rready[RP_VS2] = rvalid_i[RP_VS2];
    exp_rready[RP_VS1] = rvalid_i[RP_VS1];
    exp_rready[RP_VD]  = rvalid_i[RP_VD];
    exp_rready[RP_LSU] = rvalid_i[RP_LSU]
                         && !claims_bank(rvalid_i[RP_VD], raddr_i[RP_VD], raddr_i[RP_LSU]);
    // sld needs either bank read port 1 or 2
    slot1_taken = claims_bank(rvalid_i[RP_VS1], raddr_i[RP_VS1], raddr_i[RP_SLD]);
    slot2_taken = claims_bank(rvalid_i[RP_VD], raddr_i[RP_VD], raddr_i[RP_SLD])
                  || claims_bank(rvalid_i[RP_LSU], raddr_i[RP_LSU], raddr_i[RP_SLD]);
    exp_rready[RP_SLD] = rvalid_i[RP_SLD] && !(slot1_taken && slot2_taken);
    for (int unsigned p = 0; p < `VRF_NR_RPORTS; p++) begin
      exp_rdata[p] = shadow_q[raddr_i[p]];
    end
  end

  //////////////////////////////////////////////////
  // Grant and data assertions
  //////////////////////////////////////////////////

  wready_match: assert property (@(posedge clk) disable iff (!rst_ni) wready_i == exp_wready)
    else begin
      err_count++;
      $error("Fail at %0t: wready_o is %b, expected %b",
             $time, $sampled(wready_i), $sampled(exp_wready));
    end

  rready_match: assert property (@(posedge clk) disable iff (!rst_ni) rready_i == exp_rready)
    else begin
      err_count++;
      $error("Fail at %0t: rready_o is %b, expected %b",
             $time, $sampled(rready_i), $sampled(exp_rready));
    end

  for (genvar p = 0; p < `VRF_NR_RPORTS; p++) begin : gen_rdata
    rdata_match: assert property (@(posedge clk) disable iff (!rst_ni)
        (rvalid_i[p] && rready_i[p]) |-> (rdata_i[p] == exp_rdata[p]))
      else begin
        err_count++;
        $error("Fail at %0t: rdata_o[%0d] is %h, expected %h",
               $time, p, $sampled(rdata_i[p]), $sampled(exp_rdata[p]));
      end

    rdata_idle: assert property (@(posedge clk) disable iff (!rst_ni)
        !rready_i[p] |-> (rdata_i[p] == '0))
      else begin
        err_count++;
        $error("Fail at %0t: rdata_o[%0d] is %h while not granted, expected 0",
               $time, p, $sampled(rdata_i[p]));
      end
  end

endmodule

/* tb/tb_vrf_top.sv */
//////////////////////////////////////////////////
// Testbench for vrf_top. Directed and random requests,
// refused writes are held until granted. All checking
// lives in the bound property module.
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "vrf_cfg.svh"

module tb_vrf_top;

  import vrf_pkg::*;

  localparam int unsigned addr_w           = $bits(vreg_addr_u);
  localparam int unsigned zero_read_cycles = 64;
  localparam int unsigned directed_cycles  = 80;
  localparam int unsigned rand_cycles      = 400;
  localparam int unsigned stim_cycles      = zero_read_cycles + directed_cycles + rand_cycles;

  logic clk;
  logic rst_ni;

  logic [`VRF_NR_WPORTS-1:0]                   wvalid;
  logic [`VRF_NR_WPORTS-1:0][addr_w-1:0]       waddr;
  logic [`VRF_NR_WPORTS-1:0][`VRF_ELEN-1:0]    wdata;
  logic [`VRF_NR_WPORTS-1:0][`VRF_ELEN/8-1:0]  wbe;
  logic [`VRF_NR_WPORTS-1:0]                   wready;
  logic [`VRF_NR_RPORTS-1:0]                   rvalid;
  logic [`VRF_NR_RPORTS-1:0][addr_w-1:0]       raddr;
  logic [`VRF_NR_RPORTS-1:0]                   rready;
  logic [`VRF_NR_RPORTS-1:0][`VRF_ELEN-1:0]    rdata;

  integer seed;

  tb_clk_gen i_clk_gen (
    .clk_o  ( clk    ),
    .rst_no ( rst_ni )
  );

  vrf_top vrf_top_i (
    .clk      ( clk    ),
    .rst_ni   ( rst_ni ),
    .wvalid_i ( wvalid ),
    .waddr_i  ( waddr  ),
    .wdata_i  ( wdata  ),
    .wbe_i    ( wbe    ),
    .wready_o ( wready ),
    .rvalid_i ( rvalid ),
    .raddr_i  ( raddr  ),
    .rready_o ( rready ),
    .rdata_o  ( rdata  )
  );

  bind vrf_top vrf_properties vrf_props_i (
    .clk      ( clk      ),
    .rst_ni   ( rst_ni   ),
    .wvalid_i ( wvalid_i ),
    .waddr_i  ( waddr_i  ),
    .wdata_i  ( wdata_i  ),
    .wbe_i    ( wbe_i    ),
    .wready_i ( wready_o ),
    .rvalid_i ( rvalid_i ),
    .raddr_i  ( raddr_i  ),
    .rready_i ( rready_o ),
    .rdata_i  ( rdata_o  )
  );

  // Address from register, bank and element
  function automatic logic [addr_w-1:0] vaddr(int unsigned vreg, int unsigned bank,
                                               int unsigned elem);
    vreg_addr_u a;
    a.fields.vreg = vreg[vreg_idx_w-1:0];
    a.fields.bank = bank[bank_idx_w-1:0];
    a.fields.elem = elem[elem_idx_w-1:0];
    return a.raw;
  endfunction

  task automatic issue_write(int unsigned p, logic [addr_w-1:0] addr, logic [31:0] data,
                             logic [3:0] be);
    wvalid[p] <= 1'b1;
    waddr[p]  <= addr;
    wdata[p]  <= data;
    wbe[p]    <= be;
  endtask

  // Hold each request until its grant is seen
  task automatic drain_writes(logic [`VRF_NR_WPORTS-1:0] req);
    logic [`VRF_NR_WPORTS-1:0] pending;
    logic [`VRF_NR_WPORTS-1:0] granted;
    pending = req;
    while (pending != '0) begin
      @(negedge clk);
      granted = pending & wready;
      @(posedge clk);
      pending = pending & ~granted;
      wvalid <= pending;
    end
  endtask

  task automatic issue_reads(logic [`VRF_NR_RPORTS-1:0] valid, logic [addr_w-1:0] a_vs2,
                             logic [addr_w-1:0] a_vs1, logic [addr_w-1:0] a_vd,
                             logic [addr_w-1:0] a_lsu, logic [addr_w-1:0] a_sld);
    rvalid        <= valid;
    raddr[RP_VS2] <= a_vs2;
    raddr[RP_VS1] <= a_vs1;
    raddr[RP_VD]  <= a_vd;
    raddr[RP_LSU] <= a_lsu;
    raddr[RP_SLD] <= a_sld;
  endtask

  task automatic clear_requests();
    wvalid <= '0;
    rvalid <= '0;
  endtask

  // New random request on every write port that is not held
  task automatic randomize_writes(logic [`VRF_NR_WPORTS-1:0] held);
    logic [31:0] r;
    for (int p = 0; p < `VRF_NR_WPORTS; p++) begin
      if (!held[p]) begin
        r = $random(seed);
        wvalid[p] <= r[0];
        waddr[p]  <= {3'b000, r[8:4]};
        wbe[p]    <= r[15:12];
        wdata[p]  <= $random(seed);
      end
    end
  endtask

  task automatic randomize_reads(logic [addr_w-1:0] mask);
    logic [31:0] r;
    r = $random(seed);
    rvalid <= r[`VRF_NR_RPORTS-1:0];
    for (int p = 0; p < `VRF_NR_RPORTS; p++) begin
      r = $random(seed);
      raddr[p] <= r[addr_w-1:0] & mask;
    end
  endtask

  initial begin : stimulus
    logic [`VRF_NR_WPORTS-1:0] held;
    seed   = 32'h7741f1f1;
    wvalid = '0;
    waddr  = '0;
    wdata  = '0;
    wbe    = '0;
    rvalid = '0;
    raddr  = '0;
    @(posedge clk);
    while (!rst_ni) @(posedge clk);

    // Idle, then reads over the whole cleared file
    repeat (4) @(posedge clk);
    for (int i = 0; i < zero_read_cycles; i++) begin
      @(posedge clk);
      randomize_reads('1);
    end
    @(posedge clk);
    clear_requests();

    // Three writers on bank 1 get one grant per cycle
    @(posedge clk);
    issue_write(WP_VD, vaddr(1, 1, 0), 32'h1111_aaaa, 4'hf);
    issue_write(WP_LSU, vaddr(2, 1, 1), 32'h2222_bbbb, 4'hf);
    issue_write(WP_SLD, vaddr(3, 1, 0), 32'h3333_cccc, 4'hf);
    drain_writes('1);
    // Writers on different banks are all granted together
    @(posedge clk);
    issue_write(WP_VD, vaddr(4, 0, 1), 32'h4444_dddd, 4'hf);
    issue_write(WP_LSU, vaddr(5, 2, 0), 32'h5555_eeee, 4'hf);
    issue_write(WP_SLD, vaddr(6, 3, 1), 32'h6666_ffff, 4'hf);
    drain_writes('1);
    @(posedge clk);
    issue_write(WP_LSU, vaddr(1, 1, 0), 32'h9988_7766, 4'b0101);
    drain_writes(3'b010);
    // Read while the same element is written
    @(posedge clk);
    issue_write(WP_VD, vaddr(4, 0, 1), 32'h0bad_cafe, 4'b0011);
    issue_reads(5'b00001, vaddr(4, 0, 1), '0, '0, '0, '0);
    drain_writes(3'b001);

    // Read groups on bank 1
    @(posedge clk);
    issue_reads(5'b11111, vaddr(1, 1, 0), vaddr(2, 1, 1), vaddr(3, 1, 0), vaddr(1, 1, 0),
                vaddr(2, 1, 1));
    @(posedge clk);
    issue_reads(5'b11101, vaddr(1, 1, 0), vaddr(2, 1, 1), vaddr(3, 1, 0), vaddr(1, 1, 0),
                vaddr(3, 1, 0));
    @(posedge clk);
    issue_reads(5'b10011, vaddr(1, 1, 0), vaddr(2, 1, 1), vaddr(3, 1, 0), vaddr(1, 1, 0),
                vaddr(2, 1, 1));
    // lsu keeps bank read port 2 while vs1 holds port 1
    @(posedge clk);
    issue_reads(5'b11011, vaddr(1, 1, 0), vaddr(2, 1, 1), vaddr(3, 1, 0), vaddr(1, 1, 0),
                vaddr(2, 1, 1));
    @(posedge clk);
    issue_reads(5'b11111, vaddr(4, 0, 1), vaddr(5, 2, 0), vaddr(6, 3, 1), vaddr(1, 1, 0),
                vaddr(4, 0, 1));
    @(posedge clk);
    clear_requests();

    // sld loses bank 0 to vd every cycle, then withdraws
    @(posedge clk);
    issue_write(WP_SLD, vaddr(7, 0, 0), 32'hdead_beef, 4'hf);
    for (int i = 0; i < 3; i++) begin
      issue_write(WP_VD, vaddr(8 + i, 0, 0), $random(seed), 4'hf);
      @(posedge clk);
    end
    clear_requests();
    @(posedge clk);
    issue_reads(5'b00011, vaddr(7, 0, 0), vaddr(8, 0, 0), '0, '0, '0);
    @(posedge clk);
    clear_requests();

    // Random traffic on a small address range
    for (int i = 0; i < rand_cycles; i++) begin
      @(negedge clk);
      held = wvalid & ~wready;
      @(posedge clk);
      randomize_writes(held);
      randomize_reads(8'h1f);
    end
    @(posedge clk);
    clear_requests();
    repeat (2) @(posedge clk);

    $display("Closing report: %0d assertion failures", vrf_top_i.vrf_props_i.err_count);
    if (vrf_top_i.vrf_props_i.err_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (stim_cycles * 2 + 200) @(posedge clk);
    $display("Timeout: stimulus did not finish within %0d clock cycles",
             stim_cycles * 2 + 200);
    $display("Verification failed");
    $finish;
  end

endmodule

/* vrf.f */
+incdir+common
common/vrf_pkg.sv
common/vrf_bank_if.sv
vrf/vrf_write_xbar.sv
vrf/vrf_read_xbar.sv
vrf/vrf_bank.sv
hdl/vrf_top.sv
tb/tb_clk_gen.sv
tb/vrf_properties.sv
tb/tb_vrf_top.sv

/* Bender.yml */
package:
  name: vrf

sources:
  # Design sources
  - target: rtl
    include_dirs:
      - common
    files:
      - common/vrf_pkg.sv
      - common/vrf_bank_if.sv
      - vrf/vrf_write_xbar.sv
      - vrf/vrf_read_xbar.sv
      - vrf/vrf_bank.sv
      - hdl/vrf_top.sv
  # Testbench sources
  - target: test
    include_dirs:
      - common
    files:
      - tb/tb_clk_gen.sv
      - tb/vrf_properties.sv
      - tb/tb_vrf_top.sv
